// File: dv/pipe_stim.txt
# T <test name> | I <instruction word, hex> | E <rd, decimal> <expected writeback, hex>
# expected writebacks are listed in program order.
T alu_basic
I 12300093
I 45600113
I 00000013
I 00000013
I 00000013
I 002081B3
I 40208233
I 0020F2B3
I 0020E333
I 0020C3B3
E 1 0000000000000123
E 2 0000000000000456
E 3 0000000000000579
E 4 FFFFFFFFFFFFFCCD
E 5 0000000000000002
E 6 0000000000000577
E 7 0000000000000575
T fwd_back_to_back
I 00A00413
I 00540493
I 00848533
I 409505B3
I 0085C633
E 8 000000000000000A
E 9 000000000000000F
E 10 0000000000000019
E 11 000000000000000A
E 12 0000000000000000
T load_use
I 7AB00693
I 00D03823
I 01003703
I 00E707B3
E 13 00000000000007AB
E 14 00000000000007AB
E 15 0000000000000F56
T x0_rules
I 05500013
I 00000833
I 05500013
I 00900893
E 16 0000000000000000
E 17 0000000000000009
T store_forward
I FFF00913
I 01203C23
I 01803983
I 01003A03
E 18 FFFFFFFFFFFFFFFF
E 19 FFFFFFFFFFFFFFFF
E 20 00000000000007AB

// File: vlog.f
source/rv_pipe_pkg.sv
source/pipe_if.sv
source/reg_file.sv
source/hazard_ctrl.sv
source/inst_decoder.sv
source/exec_unit.sv
source/mem_stage.sv
source/rv_int_pipe.sv
dv/tb_rv_int_pipe.sv

// File: Bender.yml
package:
  name: rv_int_pipe

dependencies: {}

sources:
  - source/rv_pipe_pkg.sv
  - source/pipe_if.sv
  - source/reg_file.sv
  - source/hazard_ctrl.sv
  - source/inst_decoder.sv
  - source/exec_unit.sv
  - source/mem_stage.sv
  - source/rv_int_pipe.sv
  - target: test
    files:
      - dv/tb_rv_int_pipe.sv

// File: dv/tb_rv_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_int_pipe
    import rv_pipe_pkg::*;
();

    logic clk;
    logic reset;
    logic [31:0] inst;
    logic inst_valid;
    logic stall;
    logic wb_valid;
    logic [reg_addr_width-1:0] wb_rd;
    logic [xlen-1:0] wb_data;

    string test_names[$];
    inst_word_u prog_inst[$];
    int prog_test[$];
    logic [reg_addr_width-1:0] ref_rd[$];
    logic [xlen-1:0] ref_data[$];
    int ref_test[$];
    logic [reg_addr_width-1:0] exp_rd_q[$]; // writebacks still owed by the running test.
    logic [xlen-1:0] exp_data_q[$];

    string cur_test;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int stall_cycles;
    int cycles;
    int cycle_limit;
    bit loaded;

    rv_int_pipe u_dut (
        .clk(clk),
        .reset(reset),
        .inst(inst),
        .inst_valid(inst_valid),
        .stall(stall),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_data(wb_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_rd(input logic [reg_addr_width-1:0] expected,
                            input logic [reg_addr_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s wb_rd expected x%0d actual x%0d", cur_test, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_data(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s wb_data expected %h actual %h", cur_test, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_stalls(input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s stall cycles expected %0d actual %0d", cur_test, expected, actual);
            test_errors++;
        end
    endtask

    // a load followed directly by a reader of its destination holds decode for one cycle.
    function automatic bit load_use_pair(input inst_word_u prev, input inst_word_u cur);
        bit reads_a;
        bit reads_b;
        reads_a = (cur.r_fmt.opcode == op_reg) || (cur.r_fmt.opcode == op_imm)
                  || (cur.r_fmt.opcode == op_load) || (cur.r_fmt.opcode == op_store);
        reads_b = (cur.r_fmt.opcode == op_reg) || (cur.r_fmt.opcode == op_store);
        return (prev.i_fmt.opcode == op_load) && (prev.i_fmt.rd != '0)
               && ((reads_a && cur.r_fmt.rs1 == prev.i_fmt.rd)
                   || (reads_b && cur.r_fmt.rs2 == prev.i_fmt.rd));
    endfunction

    // writebacks are registered at the rising edge, so they are sampled on the falling one.
    always @(negedge clk) begin
        if (!reset && stall) begin
            stall_cycles++; // one cycle of decode held.
        end
        if (!reset && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("test %s: writeback to x%0d was not expected", cur_test, wb_rd);
                test_errors++;
            end else begin
                check_rd(exp_rd_q.pop_front(), wb_rd);
                check_data(exp_data_q.pop_front(), wb_data);
            end
        end
    end

    task automatic load_stim(output bit ok);
        int fd;
        int code;
        string line;
        string name;
        logic [31:0] word;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0] data;
        ok = 1'b0;
        fd = $fopen("dv/pipe_stim.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0) begin
                    case (line[0])
                        "T": begin
                            code = $sscanf(line, "T %s", name);
                            test_names.push_back(name);
                        end
                        "I": begin
                            code = $sscanf(line, "I %h", word);
                            prog_inst.push_back(word);
                            prog_test.push_back(test_names.size() - 1);
                        end
                        "E": begin
                            code = $sscanf(line, "E %d %h", rd, data);
                            ref_rd.push_back(rd);
                            ref_data.push_back(data);
                            ref_test.push_back(test_names.size() - 1);
                        end
                        default: code = 1; // comments and blank lines.
                    endcase
                    if (code < 1) begin
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (test_names.size() == 0) begin
                ok = 1'b0;
            end
        end
    endtask

    // called just after a rising edge, returns just after the edge that took the word.
    task automatic issue_inst(input inst_word_u word);
        inst = word;
        inst_valid = 1'b1;
        @(negedge clk);
        while (stall) begin
            @(negedge clk); // the word is held until decode frees up.
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input int t);
        int waited;
        int exp_stalls;
        inst_word_u prev;
        cur_test = test_names[t];
        test_errors = 0;
        waited = 0;
        exp_stalls = 0;
        prev = '0;
        stall_cycles = 0;
        for (int i = 0; i < ref_rd.size(); i++) begin
            if (ref_test[i] == t) begin
                exp_rd_q.push_back(ref_rd[i]);
                exp_data_q.push_back(ref_data[i]);
            end
        end
        for (int i = 0; i < prog_inst.size(); i++) begin
            if (prog_test[i] == t) begin
                if (load_use_pair(prev, prog_inst[i])) begin
                    exp_stalls++;
                end
                issue_inst(prog_inst[i]);
                prev = prog_inst[i];
            end
        end
        inst_valid = 1'b0;
        inst = '0;
        while (exp_rd_q.size() > 0 && waited < 16) begin // well past the pipeline depth.
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_rd_q.size() > 0) begin
            $display("test %s: %0d expected writebacks never arrived", cur_test, exp_rd_q.size());
            test_errors += exp_rd_q.size();
            exp_rd_q.delete();
            exp_data_q.delete();
        end
        check_stalls(exp_stalls, stall_cycles);
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst = '0;
        inst_valid = 1'b0;
        cycles = 0;
        cycle_limit = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors = 0;
        stall_cycles = 0;
        cur_test = "reset";
        load_stim(loaded);
        if (!loaded) begin
            $display("could not read the stimulus file dv/pipe_stim.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            cycle_limit = 20 * prog_inst.size() + 100;
            repeat (5) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int t = 0; t < test_names.size(); t++) begin
                run_test(t);
            end
            $display("tests passed %0d failed %0d", tests_passed, tests_failed);
            if (tests_failed == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: source/rv_int_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module rv_int_pipe
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic [31:0] inst,
    input  logic inst_valid,
    output logic stall,
    output logic wb_valid,
    output logic [reg_addr_width-1:0] wb_rd,
    output logic [xlen-1:0] wb_data
);

    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic uses_rs1;
    logic uses_rs2;
    logic id_valid;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic [reg_addr_width-1:0] rd_addr_a;
    logic [reg_addr_width-1:0] rd_addr_b;
    logic [xlen-1:0] rd_data_a;
    logic [xlen-1:0] rd_data_b;
    logic [xlen-1:0] store_data;

    issue_if issue ();
    result_if ex_res ();
    result_if mem_res ();
    result_if wb_res ();

    inst_decoder u_inst_decoder (
        .clk(clk),
        .reset(reset),
        .inst(inst),
        .inst_valid(inst_valid),
        .stall(stall),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .rs1(rs1),
        .rs2(rs2),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .id_valid(id_valid),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .issue(issue.src),
        .ex_res(ex_res.src)
    );

    reg_file u_reg_file (
        .clk(clk),
        .reset(reset),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b),
        .wb_res(wb_res.sink)
    );

    hazard_ctrl u_hazard_ctrl (
        .rs1(rs1),
        .rs2(rs2),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .id_valid(id_valid),
        .ex_res(ex_res.snoop),
        .mem_res(mem_res.snoop),
        .stall(stall),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    exec_unit u_exec_unit (
        .clk(clk),
        .reset(reset),
        .issue(issue.dst),
        .wb_res(wb_res.snoop),
        .mem_res(mem_res.src),
        .store_data(store_data)
    );

    mem_stage u_mem_stage (
        .clk(clk),
        .reset(reset),
        .mem_res(mem_res.dst),
        .store_data(store_data),
        .wb_res(wb_res.src)
    );

    assign wb_valid = wb_res.valid && wb_res.writes_rd; // stores reach writeback silently.
    assign wb_rd = wb_res.rd;
    assign wb_data = wb_res.data;

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic reset,
    result_if.dst mem_res,
    input  logic [xlen-1:0] store_data,
    result_if.src wb_res
);

    logic [xlen-1:0] ram [dmem_words];
    logic [dmem_addr_width-1:0] index;
    logic store_en;

    assign index = mem_res.data[dmem_addr_width+2:3]; // doubleword index.
    assign store_en = mem_res.valid && !mem_res.writes_rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dmem_words; i++) begin
                ram[i] <= '0;
            end
        end else if (store_en) begin
            ram[index] <= store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_res.valid <= 1'b0;
        end else begin
            wb_res.valid <= mem_res.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_res.rd <= mem_res.rd;
        wb_res.writes_rd <= mem_res.writes_rd;
        wb_res.is_load <= mem_res.is_load;
        wb_res.data <= mem_res.is_load ? ram[index] : mem_res.data;
    end

endmodule

`default_nettype wire

// File: source/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic reset,
    issue_if.dst issue,
    result_if.snoop wb_res,
    result_if.src mem_res,
    output logic [xlen-1:0] store_data
);

    logic [xlen-1:0] opnd_a;
    logic [xlen-1:0] opnd_b;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_res;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e sel,
        input logic [xlen-1:0] reg_data,
        input logic [xlen-1:0] mem_data,
        input logic [xlen-1:0] wb_data
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_mem: value = mem_data;
            fwd_wb: value = wb_data;
            default: value = reg_data;
        endcase
        return value;
    endfunction

    assign opnd_a = fwd_mux(issue.fwd_a, issue.rs1_data, mem_res.data, wb_res.data);
    assign opnd_b = fwd_mux(issue.fwd_b, issue.rs2_data, mem_res.data, wb_res.data);
    assign alu_b = issue.use_imm ? issue.imm : opnd_b;

    always_comb begin
        case (issue.alu_op)
            alu_sub: alu_res = opnd_a - alu_b;
            alu_and: alu_res = opnd_a & alu_b;
            alu_or: alu_res = opnd_a | alu_b;
            alu_xor: alu_res = opnd_a ^ alu_b;
            default: alu_res = opnd_a + alu_b; // also the ld and sd address.
        endcase
    end

    // only register writers and stores stay valid past execute, so a valid entry
    // without a destination is a store.
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_res.valid <= 1'b0;
        end else begin
            mem_res.valid <= issue.valid && (issue.writes_rd || issue.is_store);
        end
    end

    always_ff @(posedge clk) begin
        mem_res.rd <= issue.rd;
        mem_res.writes_rd <= issue.writes_rd;
        mem_res.is_load <= issue.is_load;
        mem_res.data <= alu_res;
        store_data <= opnd_b; // rs2 after forwarding.
    end

endmodule

`default_nettype wire

// File: source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  inst_word_u inst,
    input  logic inst_valid,
    input  logic stall,
    input  fwd_sel_e fwd_a,
    input  fwd_sel_e fwd_b,
    output logic [reg_addr_width-1:0] rs1,
    output logic [reg_addr_width-1:0] rs2,
    output logic uses_rs1,
    output logic uses_rs2,
    output logic id_valid,
    output logic [reg_addr_width-1:0] rd_addr_a,
    output logic [reg_addr_width-1:0] rd_addr_b,
    input  logic [xlen-1:0] rd_data_a,
    input  logic [xlen-1:0] rd_data_b,
    issue_if.src issue,
    result_if.src ex_res
);

    logic id_valid_q;
    inst_word_u id_inst;
    logic dec_ok;
    alu_op_e dec_alu_op;
    logic [xlen-1:0] dec_imm;
    logic dec_use_imm;
    logic dec_writes;
    logic dec_load;
    logic dec_store;

    always_comb begin
        dec_ok = 1'b0;
        dec_alu_op = alu_add; // loads and stores add the offset.
        dec_imm = {{(xlen-12){id_inst.i_fmt.imm12[11]}}, id_inst.i_fmt.imm12};
        dec_use_imm = 1'b1;
        dec_writes = 1'b0;
        dec_load = 1'b0;
        dec_store = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (id_inst.r_fmt.opcode)
            op_reg: begin
                dec_use_imm = 1'b0;
                dec_writes = 1'b1;
                uses_rs2 = 1'b1;
                dec_ok = 1'b1;
                if (id_inst.r_fmt.funct7 == f7_sub && id_inst.r_fmt.funct3 == f3_add_sub) begin
                    dec_alu_op = alu_sub;
                end else if (id_inst.r_fmt.funct7 != f7_base) begin
                    dec_ok = 1'b0;
                end else begin
                    case (id_inst.r_fmt.funct3)
                        f3_add_sub: dec_alu_op = alu_add;
                        f3_xor: dec_alu_op = alu_xor;
                        f3_or: dec_alu_op = alu_or;
                        f3_and: dec_alu_op = alu_and;
                        default: dec_ok = 1'b0;
                    endcase
                end
            end
            op_imm: begin
                dec_writes = 1'b1;
                dec_ok = (id_inst.i_fmt.funct3 == f3_add_sub);
            end
            op_load: begin
                dec_writes = 1'b1;
                dec_load = 1'b1;
                dec_ok = (id_inst.i_fmt.funct3 == f3_double);
            end
            op_store: begin
                dec_imm = {{(xlen-12){id_inst.s_fmt.imm_hi[6]}},
                           id_inst.s_fmt.imm_hi, id_inst.s_fmt.imm_lo};
                dec_store = 1'b1;
                uses_rs2 = 1'b1;
                dec_ok = (id_inst.s_fmt.funct3 == f3_double);
            end
            default: dec_ok = 1'b0;
        endcase
        if (!dec_ok) begin
            uses_rs1 = 1'b0; // unsupported words travel on as bubbles.
            uses_rs2 = 1'b0;
        end
    end

    assign rs1 = id_inst.r_fmt.rs1;
    assign rs2 = id_inst.r_fmt.rs2;
    assign rd_addr_a = id_inst.r_fmt.rs1;
    assign rd_addr_b = id_inst.r_fmt.rs2;
    assign id_valid = id_valid_q && dec_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid_q <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            if (!stall) begin
                id_valid_q <= inst_valid;
            end
            issue.valid <= id_valid && !stall; // a stall sends a bubble into execute.
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_inst <= inst;
        end
        issue.alu_op <= dec_alu_op;
        issue.rd <= id_inst.r_fmt.rd;
        issue.writes_rd <= dec_writes && (id_inst.r_fmt.rd != '0);
        issue.is_load <= dec_load;
        issue.is_store <= dec_store;
        issue.rs1_data <= rd_data_a;
        issue.rs2_data <= rd_data_b;
        issue.imm <= dec_imm;
        issue.use_imm <= dec_use_imm;
        issue.fwd_a <= fwd_a;
        issue.fwd_b <= fwd_b;
    end

    assign ex_res.valid = issue.valid;
    assign ex_res.rd = issue.rd;
    assign ex_res.writes_rd = issue.writes_rd;
    assign ex_res.is_load = issue.is_load;
    assign ex_res.data = '0; // the result is only known at the end of execute.

endmodule

`default_nettype wire

// File: source/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl
    import rv_pipe_pkg::*;
(
    input  logic [reg_addr_width-1:0] rs1,
    input  logic [reg_addr_width-1:0] rs2,
    input  logic uses_rs1,
    input  logic uses_rs2,
    input  logic id_valid,
    result_if.snoop ex_res,
    result_if.snoop mem_res,
    output logic stall,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b
);

    logic ex_hit_a;
    logic ex_hit_b;
    logic mem_hit_a;
    logic mem_hit_b;

    function automatic logic src_hit(
        input logic [reg_addr_width-1:0] src,
        input logic used,
        input logic stage_valid,
        input logic stage_writes,
        input logic [reg_addr_width-1:0] stage_rd
    );
        return used && (src != '0) && stage_valid && stage_writes && (src == stage_rd);
    endfunction

    // the selects are registered with the instruction, so each producer has moved
    // one stage on by the time the consumer executes.
    function automatic fwd_sel_e pick_source(input logic ex_hit, input logic mem_hit);
        return ex_hit ? fwd_mem : (mem_hit ? fwd_wb : fwd_none);
    endfunction

    assign ex_hit_a = src_hit(rs1, uses_rs1, ex_res.valid, ex_res.writes_rd, ex_res.rd);
    assign ex_hit_b = src_hit(rs2, uses_rs2, ex_res.valid, ex_res.writes_rd, ex_res.rd);
    assign mem_hit_a = src_hit(rs1, uses_rs1, mem_res.valid, mem_res.writes_rd, mem_res.rd);
    assign mem_hit_b = src_hit(rs2, uses_rs2, mem_res.valid, mem_res.writes_rd, mem_res.rd);

    assign fwd_a = pick_source(ex_hit_a, mem_hit_a);
    assign fwd_b = pick_source(ex_hit_b, mem_hit_b);

    // load data only exists after the memory stage, one cycle too late for execute.
    assign stall = id_valid && ex_res.is_load && (ex_hit_a || ex_hit_b);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_pipe_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic [reg_addr_width-1:0] rd_addr_a,
    input  logic [reg_addr_width-1:0] rd_addr_b,
    output logic [xlen-1:0] rd_data_a,
    output logic [xlen-1:0] rd_data_b,
    result_if.sink wb_res
);

    logic [xlen-1:0] regs [1:(1 << reg_addr_width)-1];

    // a register written this cycle reads back as the new value.
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        logic [xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_res.valid && wb_res.writes_rd && wb_res.rd == addr) begin
            value = wb_res.data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < (1 << reg_addr_width); i++) begin
                regs[i] <= '0;
            end
        end else if (wb_res.valid && wb_res.writes_rd && wb_res.rd != '0) begin
            regs[wb_res.rd] <= wb_res.data;
        end
    end

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

`default_nettype wire

// File: source/pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if
    import rv_pipe_pkg::*;
();
    logic valid;
    alu_op_e alu_op;
    logic [reg_addr_width-1:0] rd;
    logic writes_rd;
    logic is_load;
    logic is_store;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    logic use_imm;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    modport src (output valid, alu_op, rd, writes_rd, is_load, is_store,
                 rs1_data, rs2_data, imm, use_imm, fwd_a, fwd_b);
    modport dst (input valid, alu_op, rd, writes_rd, is_load, is_store,
                 rs1_data, rs2_data, imm, use_imm, fwd_a, fwd_b);
endinterface

interface result_if
    import rv_pipe_pkg::*;
();
    logic valid;
    logic [reg_addr_width-1:0] rd;
    logic writes_rd; // never set for x0.
    logic is_load;
    logic [xlen-1:0] data;

    modport src (output valid, rd, writes_rd, is_load, data);
    modport dst (input valid, rd, writes_rd, is_load, data);
    modport snoop (input valid, rd, writes_rd, is_load, data);
    modport sink (input valid, rd, writes_rd, is_load, data);
endinterface

`default_nettype wire

// File: source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    localparam int xlen = 64;
    localparam int reg_addr_width = 5;
    localparam int dmem_words = 32;
    localparam int dmem_addr_width = $clog2(dmem_words);

    localparam logic [6:0] op_reg = 7'b0110011;
    localparam logic [6:0] op_imm = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam logic [2:0] f3_add_sub = 3'b000; // also addi.
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_double = 3'b011; // ld and sd.

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [reg_addr_width-1:0] rs2;
            logic [reg_addr_width-1:0] rs1;
            logic [2:0] funct3;
            logic [reg_addr_width-1:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [reg_addr_width-1:0] rs1;
            logic [2:0] funct3;
            logic [reg_addr_width-1:0] rd;
            logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [reg_addr_width-1:0] rs2;
            logic [reg_addr_width-1:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
    } inst_word_u;

endpackage

`default_nettype wire
